/* verilog.f */
source/fpu_pkg.sv
source/fpu_register_stack.sv
source/fpu_int_converter.sv
source/fpu_status_control.sv
source/fpu_sequencer.sv
source/fpu_core.sv
verif/fpu_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the FPU core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fpu_core_tb -f verilog.f -o fpu_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/fpu_core_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

/* verif/fpu_core_tb.sv */
`timescale 1ns/1ps

module fpu_core_tb;

    import fpu_pkg::*;

    localparam int MAX_ROWS = 64;
    localparam int LATENCY  = 3;  // Cycles from accepted execute to ready

    // Operands with known extended encodings
    localparam fp80_t VAL_A     = 80'h4000_C90F_DAA2_2168_C235;  // Pi
    localparam fp80_t VAL_B     = 80'hC002_A000_0000_0000_0000;  // -10
    localparam fp80_t PLUS_ONE  = 80'h3FFF_8000_0000_0000_0000;
    localparam fp80_t MINUS_ONE = 80'hBFFF_8000_0000_0000_0000;
    localparam fp80_t INT_MAX   = 80'h401D_FFFF_FFFE_0000_0000;  // 2^31 - 1
    localparam fp80_t INT_MIN   = 80'hC01E_8000_0000_0000_0000;  // -2^31
    localparam fp80_t BIG_VALUE = 80'h7FFE_FFFF_FFFF_FFFF_FFFF;  // Never lands on the stack

    logic         clk = 1'b0;
    logic         reset;
    fpu_opcode_e  instruction;
    stack_index_t stack_index;
    logic         execute;
    fp80_t        data_in;
    logic [31:0]  int_data_in;
    logic [15:0]  control_in;
    logic         ready;
    logic         error;
    fp80_t        data_out;
    logic [15:0]  status_out;
    logic [15:0]  control_out;
    logic [15:0]  tag_word_out;

    // ========================================
    // Stimulus and expected values
    // ========================================

    string        row_name       [MAX_ROWS];
    fpu_opcode_e  row_op         [MAX_ROWS];
    stack_index_t row_index      [MAX_ROWS];
    fp80_t        row_data       [MAX_ROWS];
    logic [31:0]  row_int        [MAX_ROWS];
    logic [15:0]  row_control    [MAX_ROWS];
    bit           row_check      [MAX_ROWS];  // Compare data_out too
    fp80_t        row_exp_data   [MAX_ROWS];
    logic [15:0]  row_exp_status [MAX_ROWS];
    logic [15:0]  row_exp_tags   [MAX_ROWS];

    int row_count   = 0;
    int error_count = 0;
    int check_count = 0;

    fpu_core i_dut (
        .clk          (clk),
        .reset        (reset),
        .instruction  (instruction),
        .stack_index  (stack_index),
        .execute      (execute),
        .data_in      (data_in),
        .int_data_in  (int_data_in),
        .control_in   (control_in),
        .ready        (ready),
        .error        (error),
        .data_out     (data_out),
        .status_out   (status_out),
        .control_out  (control_out),
        .tag_word_out (tag_word_out)
    );

    always #4 clk = ~clk;  // 8 ns period

    task automatic add_row(input string name, input fpu_opcode_e op,
                           input stack_index_t index, input fp80_t data,
                           input logic [31:0] int_value, input logic [15:0] control,
                           input bit check_data, input fp80_t exp_data,
                           input logic [15:0] exp_status, input logic [15:0] exp_tags);
        row_name[row_count]       = name;
        row_op[row_count]         = op;
        row_index[row_count]      = index;
        row_data[row_count]       = data;
        row_int[row_count]        = int_value;
        row_control[row_count]    = control;
        row_check[row_count]      = check_data;
        row_exp_data[row_count]   = exp_data;
        row_exp_status[row_count] = exp_status;
        row_exp_tags[row_count]   = exp_tags;
        row_count++;
    endtask

    // Distinct nonzero value for the k-th push of the overflow test
    function automatic fp80_t push_value(input int k);
        fp80_t value;
        value.sign        = 1'b0;
        value.exponent    = 15'h4000 + 15'(k);
        value.significand = 64'hA000_0000_0000_0000 | 64'(k);
        return value;
    endfunction

    task automatic build_table();
        logic [15:0] push_status;
        // Two pushes, reads, exchange and pops
        add_row("fld a", op_fld, 3'd0, VAL_A, 32'd0, 16'h0, 1'b0, '0, 16'h3800, 16'h3FFF);
        add_row("fld b", op_fld, 3'd0, VAL_B, 32'd0, 16'h0, 1'b0, '0, 16'h3000, 16'h0FFF);
        add_row("fst st0", op_fst, 3'd0, '0, 32'd0, 16'h0, 1'b1, VAL_B, 16'h3000, 16'h0FFF);
        add_row("fst st1", op_fst, 3'd1, '0, 32'd0, 16'h0, 1'b1, VAL_A, 16'h3000, 16'h0FFF);
        add_row("fxch st1", op_fxch, 3'd1, '0, 32'd0, 16'h0, 1'b0, '0, 16'h3000, 16'h0FFF);
        add_row("fst st0 swapped", op_fst, 3'd0, '0, 32'd0, 16'h0, 1'b1, VAL_A,
                16'h3000, 16'h0FFF);
        add_row("fst st1 swapped", op_fst, 3'd1, '0, 32'd0, 16'h0, 1'b1, VAL_B,
                16'h3000, 16'h0FFF);
        add_row("fstp a", op_fstp, 3'd0, '0, 32'd0, 16'h0, 1'b1, VAL_A, 16'h3800, 16'h3FFF);
        add_row("fstp b", op_fstp, 3'd0, '0, 32'd0, 16'h0, 1'b1, VAL_B, 16'h0000, 16'hFFFF);

        // Integer loads read back in reverse order
        add_row("fild32 1", op_fild32, 3'd0, '0, 32'h0000_0001, 16'h0, 1'b0, '0,
                16'h3800, 16'h3FFF);
        add_row("fild32 -1", op_fild32, 3'd0, '0, 32'hFFFF_FFFF, 16'h0, 1'b0, '0,
                16'h3000, 16'h0FFF);
        add_row("fild32 max", op_fild32, 3'd0, '0, 32'h7FFF_FFFF, 16'h0, 1'b0, '0,
                16'h2800, 16'h03FF);
        add_row("fild32 min", op_fild32, 3'd0, '0, 32'h8000_0000, 16'h0, 1'b0, '0,
                16'h2000, 16'h00FF);
        add_row("fild16 -1", op_fild16, 3'd0, '0, 32'h1234_FFFF, 16'h0, 1'b0, '0,
                16'h1800, 16'h003F);  // Upper half ignored
        add_row("fstp fild16 -1", op_fstp, 3'd0, '0, 32'd0, 16'h0, 1'b1, MINUS_ONE,
                16'h2000, 16'h00FF);
        add_row("fstp fild32 min", op_fstp, 3'd0, '0, 32'd0, 16'h0, 1'b1, INT_MIN,
                16'h2800, 16'h03FF);
        add_row("fstp fild32 max", op_fstp, 3'd0, '0, 32'd0, 16'h0, 1'b1, INT_MAX,
                16'h3000, 16'h0FFF);
        add_row("fstp fild32 -1", op_fstp, 3'd0, '0, 32'd0, 16'h0, 1'b1, MINUS_ONE,
                16'h3800, 16'h3FFF);
        add_row("fstp fild32 1", op_fstp, 3'd0, '0, 32'd0, 16'h0, 1'b1, PLUS_ONE,
                16'h0000, 16'hFFFF);
        add_row("fild32 0", op_fild32, 3'd0, '0, 32'd0, 16'h0, 1'b0, '0,
                16'h3800, 16'h7FFF);  // Zero tag on register 7
        add_row("fstp fild32 0", op_fstp, 3'd0, '0, 32'd0, 16'h0, 1'b1, '0,
                16'h0000, 16'hFFFF);

        // Underflow, unmasking and clearing
        add_row("fst empty", op_fst, 3'd0, '0, 32'd0, 16'h0, 1'b1, FP80_INDEFINITE,
                16'h0041, 16'hFFFF);
        add_row("fldcw unmask ie", op_fldcw, 3'd0, '0, 32'd0, 16'h037E, 1'b0, '0,
                16'h00C1, 16'hFFFF);
        add_row("fclex", op_fclex, 3'd0, '0, 32'd0, 16'h0, 1'b0, '0, 16'h0000, 16'hFFFF);

        // Fill all eight registers
        for (int k = 1; k <= STACK_DEPTH; k++) begin
            push_status                   = '0;
            push_status[SW_TOP_LSB +: 3] = 3'(8 - k);
            add_row($sformatf("push %0d", k), op_fld, 3'd0, push_value(k), 32'd0, 16'h0,
                    1'b0, '0, push_status, 16'hFFFF >> (2 * k));
        end

        // Overflow with IE unmasked raises ES and error too
        add_row("push overflow", op_fld, 3'd0, BIG_VALUE, 32'd0, 16'h0, 1'b0, '0,
                16'h02C1, 16'h0000);
        add_row("fst st0 full", op_fst, 3'd0, '0, 32'd0, 16'h0, 1'b1, push_value(8),
                16'h02C1, 16'h0000);
        add_row("fst st7 full", op_fst, 3'd7, '0, 32'd0, 16'h0, 1'b1, push_value(1),
                16'h02C1, 16'h0000);

        // Flags clear again, C1 stays from the overflow
        add_row("fclex full", op_fclex, 3'd0, '0, 32'd0, 16'h0, 1'b0, '0,
                16'h0200, 16'h0000);
        add_row("unknown opcode", fpu_opcode_e'(8'h55), 3'd3, BIG_VALUE, 32'h1, 16'h0,
                1'b1, push_value(1), 16'h0200, 16'h0000);
        add_row("fst st3 after unknown", op_fst, 3'd3, '0, 32'd0, 16'h0, 1'b1,
                push_value(5), 16'h0200, 16'h0000);
    endtask

    // ========================================
    // Drive and compare
    // ========================================

    task automatic check_word(input string test, input string signal,
                              input logic [15:0] expected, input logic [15:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("MISMATCH %s %s expected %h actual %h", test, signal, expected, actual);
        end
    endtask

    task automatic check_real(input string test, input string signal,
                              input fp80_t expected, input fp80_t actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("MISMATCH %s %s expected %h actual %h", test, signal, expected, actual);
        end
    endtask

    // One cycle of execute with inputs held until ready returns
    task automatic run_row(input int i, output int latency);
        instruction = row_op[i];
        stack_index = row_index[i];
        data_in     = row_data[i];
        int_data_in = row_int[i];
        control_in  = row_control[i];
        execute     = 1'b1;
        @(negedge clk);
        execute = 1'b0;
        latency = 0;
        while (!ready) begin
            @(negedge clk);
            latency++;
        end
    endtask

    task automatic check_row(input int i, input int latency);
        check_word(row_name[i], "latency", 16'(LATENCY), 16'(latency));
        check_word(row_name[i], "status_out", row_exp_status[i], status_out);
        check_word(row_name[i], "tag_word_out", row_exp_tags[i], tag_word_out);
        check_word(row_name[i], "error", 16'(row_exp_status[i][SW_ES]), 16'(error));
        if (row_check[i])
            check_real(row_name[i], "data_out", row_exp_data[i], data_out);
    endtask

    // Watchdog sized from the table length
    initial begin
        @(negedge reset);
        repeat ((row_count * 3 + 20) * 2) @(posedge clk);
        $display("Timeout: ready did not return within %0d cycles of reset",
                 (row_count * 3 + 20) * 2);
        $display("test failed");
        $finish;
    end

    initial begin
        int latency;
        reset       = 1'b1;
        instruction = op_nop;
        stack_index = '0;
        execute     = 1'b0;
        data_in     = '0;
        int_data_in = 32'd0;
        control_in  = 16'h0;
        build_table();

        repeat (8) @(negedge clk);
        reset = 1'b0;

        check_word("reset", "ready", 16'h0001, 16'(ready));
        check_word("reset", "error", 16'h0000, 16'(error));
        check_word("reset", "status_out", 16'h0000, status_out);
        check_word("reset", "control_out", CONTROL_RESET, control_out);
        check_word("reset", "tag_word_out", 16'hFFFF, tag_word_out);
        check_real("reset", "data_out", '0, data_out);

        for (int i = 0; i < row_count; i++) begin
            run_row(i, latency);
            check_row(i, latency);
        end
        check_word("final", "control_out", 16'h037E, control_out);  // Left by FLDCW

        $display("%0d errors in %0d checks", error_count, check_count);
        if (error_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* source/fpu_core.sv */
`timescale 1ns/1ps

module fpu_core (
    input  logic                  clk,
    input  logic                  reset,
    input  fpu_pkg::fpu_opcode_e  instruction,
    input  fpu_pkg::stack_index_t stack_index,
    input  logic                  execute,
    input  fpu_pkg::fp80_t        data_in,
    input  logic [31:0]           int_data_in,
    input  logic [15:0]           control_in,
    output logic                  ready,
    output logic                  error,
    output fpu_pkg::fp80_t        data_out,
    output logic [15:0]           status_out,
    output logic [15:0]           control_out,
    output logic [15:0]           tag_word_out
);

    import fpu_pkg::*;

    // Sequencer to stack
    logic         push;
    logic         pop;
    logic         exchange;
    logic         write_enable;
    fp80_t        write_data;
    stack_index_t read_index;

    // Stack to sequencer and status unit
    fp80_t        st0;
    fp80_t        sti;
    logic         st0_empty;
    logic         sti_empty;
    logic         full;
    stack_index_t top;

    // Converter path
    logic [31:0]  int_operand;
    fp80_t        converted;

    // Sequencer to status unit
    logic         busy;
    logic         stack_overflow;
    logic         stack_underflow;
    logic         clear_exceptions;
    logic         load_control;
    logic [15:0]  control_word_in;

    fpu_sequencer i_sequencer (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .stack_index      (stack_index),
        .execute          (execute),
        .data_in          (data_in),
        .int_data_in      (int_data_in),
        .control_in       (control_in),
        .st0              (st0),
        .sti              (sti),
        .st0_empty        (st0_empty),
        .sti_empty        (sti_empty),
        .full             (full),
        .converted        (converted),
        .ready            (ready),
        .data_out         (data_out),
        .int_operand      (int_operand),
        .push             (push),
        .pop              (pop),
        .exchange         (exchange),
        .write_enable     (write_enable),
        .write_data       (write_data),
        .read_index       (read_index),
        .busy             (busy),
        .stack_overflow   (stack_overflow),
        .stack_underflow  (stack_underflow),
        .clear_exceptions (clear_exceptions),
        .load_control     (load_control),
        .control_word_in  (control_word_in)
    );

    fpu_register_stack i_register_stack (
        .clk          (clk),
        .reset        (reset),
        .push         (push),
        .pop          (pop),
        .exchange     (exchange),
        .write_enable (write_enable),
        .write_data   (write_data),
        .read_index   (read_index),
        .st0          (st0),
        .sti          (sti),
        .st0_empty    (st0_empty),
        .sti_empty    (sti_empty),
        .full         (full),
        .top          (top),
        .tag_word     (tag_word_out)
    );

    fpu_int_converter i_int_converter (
        .int_operand (int_operand),
        .converted   (converted)
    );

    fpu_status_control i_status_control (
        .clk              (clk),
        .reset            (reset),
        .busy             (busy),
        .stack_overflow   (stack_overflow),
        .stack_underflow  (stack_underflow),
        .clear_exceptions (clear_exceptions),
        .load_control     (load_control),
        .control_in       (control_word_in),
        .top              (top),
        .status_out       (status_out),
        .control_out      (control_out),
        .error            (error)
    );

endmodule

/* source/fpu_sequencer.sv */
`timescale 1ns/1ps

module fpu_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  fpu_pkg::fpu_opcode_e  instruction,
    input  fpu_pkg::stack_index_t stack_index,
    input  logic                  execute,
    input  fpu_pkg::fp80_t        data_in,
    input  logic [31:0]           int_data_in,
    input  logic [15:0]           control_in,
    input  fpu_pkg::fp80_t        st0,
    input  fpu_pkg::fp80_t        sti,
    input  logic                  st0_empty,
    input  logic                  sti_empty,
    input  logic                  full,
    input  fpu_pkg::fp80_t        converted,
    output logic                  ready,
    output fpu_pkg::fp80_t        data_out,
    output logic [31:0]           int_operand,
    output logic                  push,
    output logic                  pop,
    output logic                  exchange,
    output logic                  write_enable,
    output fpu_pkg::fp80_t        write_data,
    output fpu_pkg::stack_index_t read_index,
    output logic                  busy,
    output logic                  stack_overflow,
    output logic                  stack_underflow,
    output logic                  clear_exceptions,
    output logic                  load_control,
    output logic [15:0]           control_word_in
);

    import fpu_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_read,
        s_exec
    } seq_state_e;

    seq_state_e   state;
    fpu_opcode_e  op_q;
    stack_index_t index_q;
    fp80_t        data_q;
    logic [31:0]  int_q;
    logic         accept;
    logic         store_op;
    fp80_t        store_value;

    assign accept = ready & execute;  // ready is only high in s_idle

    // ========================================
    // Operand capture
    // ========================================

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= data_in;
            if (instruction == op_fild16)
                int_q <= {{16{int_data_in[15]}}, int_data_in[15:0]};
            else
                int_q <= int_data_in;
        end
    end

    // ========================================
    // Sequence control
    // ========================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= s_idle;
            ready    <= 1'b1;
            op_q     <= op_nop;
            index_q  <= '0;
            data_out <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (!ready) begin
                        ready <= 1'b1;  // Wrap-up cycle after s_exec
                    end else if (execute) begin
                        ready   <= 1'b0;
                        op_q    <= instruction;
                        index_q <= stack_index;
                        state   <= s_read;
                    end
                end
                s_read: state <= s_exec;  // Stack read ports settle on index_q
                s_exec: begin
                    if (store_op)
                        data_out <= store_value;
                    state <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

    // ========================================
    // Fault decisions and pulses
    // ========================================

    always_comb begin
        push             = 1'b0;
        pop              = 1'b0;
        exchange         = 1'b0;
        stack_overflow   = 1'b0;
        stack_underflow  = 1'b0;
        clear_exceptions = 1'b0;
        load_control     = 1'b0;
        store_op         = 1'b0;
        store_value      = sti;

        if (state == s_exec) begin
            case (op_q)
                op_fld, op_fild16, op_fild32: begin
                    if (full)
                        stack_overflow = 1'b1;
                    else
                        push = 1'b1;
                end
                op_fst: begin
                    store_op        = 1'b1;
                    stack_underflow = sti_empty;
                    store_value     = sti_empty ? FP80_INDEFINITE : sti;
                end
                op_fstp: begin
                    store_op        = 1'b1;
                    stack_underflow = st0_empty;
                    pop             = ~st0_empty;
                    store_value     = st0_empty ? FP80_INDEFINITE : st0;
                end
                op_fxch: begin
                    if (st0_empty || sti_empty)
                        stack_underflow = 1'b1;
                    else
                        exchange = 1'b1;
                end
                op_fldcw: load_control     = 1'b1;
                op_fclex: clear_exceptions = 1'b1;
                default: ;  // op_nop and unknown encodings
            endcase
        end
    end

    // Loads push, nothing in this set rewrites ST(0) in place
    assign write_enable = 1'b0;
    assign write_data   = (op_q == op_fld) ? data_q : converted;

    assign int_operand     = int_q;
    assign read_index      = index_q;
    assign busy            = (state != s_idle);
    assign control_word_in = control_in;

endmodule

/* source/fpu_status_control.sv */
`timescale 1ns/1ps

module fpu_status_control (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  busy,
    input  logic                  stack_overflow,
    input  logic                  stack_underflow,
    input  logic                  clear_exceptions,
    input  logic                  load_control,
    input  logic [15:0]           control_in,
    input  fpu_pkg::stack_index_t top,
    output logic [15:0]           status_out,
    output logic [15:0]           control_out,
    output logic                  error
);

    import fpu_pkg::*;

    logic [15:0] control_word;
    logic        busy_q;
    logic        ie;    // Sticky invalid operation
    logic        sf;    // Sticky stack fault
    logic        c1;    // Overflow vs underflow on a stack fault
    logic        es;

    // ========================================
    // Control word and flags
    // ========================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            control_word <= CONTROL_RESET;
            busy_q       <= 1'b0;
            ie           <= 1'b0;
            sf           <= 1'b0;
            c1           <= 1'b0;
        end else begin
            busy_q <= busy;
            if (load_control)
                control_word <= control_in;
            if (clear_exceptions) begin
                ie <= 1'b0;
                sf <= 1'b0;
            end
            // Any stack fault is an invalid operation
            if (stack_overflow || stack_underflow) begin
                ie <= 1'b1;
                sf <= 1'b1;
                c1 <= stack_overflow;  // 1 on overflow, 0 on underflow
            end
        end
    end

    // Only IE can be unmasked here, SF rides along with it
    assign es = ie & ~control_word[CW_IM];

    // ========================================
    // Status word assembly
    // ========================================

    always_comb begin
        status_out                     = '0;
        status_out[SW_BUSY]            = busy_q;
        status_out[SW_TOP_LSB +: 3]    = top;
        status_out[SW_C1]              = c1;
        status_out[SW_ES]              = es;
        status_out[SW_SF]              = sf;
        status_out[SW_IE]              = ie;
    end

    assign control_out = control_word;
    assign error       = es;

endmodule

/* source/fpu_int_converter.sv */
`timescale 1ns/1ps

module fpu_int_converter (
    input  logic [31:0]    int_operand,
    output fpu_pkg::fp80_t converted
);

    import fpu_pkg::*;

    logic        sign;
    logic [31:0] magnitude;
    logic [4:0]  lz_count;
    logic [31:0] normalized;

    assign sign = int_operand[31];

    // 80000000h negates to itself, still the right magnitude unsigned
    assign magnitude = sign ? (~int_operand + 32'd1) : int_operand;

    // Highest set bit wins, so the last hit of the loop counts
    always_comb begin
        lz_count = 5'd0;
        for (int i = 0; i < 32; i++) begin
            if (magnitude[i])
                lz_count = 5'(31 - i);
        end
    end

    assign normalized = magnitude << lz_count;  // Bit 31 now the integer bit

    always_comb begin
        if (magnitude == 32'd0) begin
            converted = '0;  // Positive zero
        end else begin
            converted.sign        = sign;
            converted.exponent    = EXP_BIAS + 15'd31 - 15'(lz_count);
            converted.significand = {normalized, 32'd0};
        end
    end

endmodule

/* source/fpu_register_stack.sv */
`timescale 1ns/1ps

module fpu_register_stack (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push,
    input  logic                  pop,
    input  logic                  exchange,
    input  logic                  write_enable,
    input  fpu_pkg::fp80_t        write_data,
    input  fpu_pkg::stack_index_t read_index,
    output fpu_pkg::fp80_t        st0,
    output fpu_pkg::fp80_t        sti,
    output logic                  st0_empty,
    output logic                  sti_empty,
    output logic                  full,
    output fpu_pkg::stack_index_t top,
    output logic [15:0]           tag_word
);

    import fpu_pkg::*;

    fp80_t        regs [STACK_DEPTH];
    tag_e         tags [STACK_DEPTH];
    stack_index_t top_q;
    stack_index_t sti_phys;   // Physical slot of ST(read_index)
    stack_index_t push_phys;  // Slot a push would take

    // Zero and valid are told apart by exponent and significand only
    function automatic tag_e tag_of(input fp80_t value);
        if (value.exponent == 15'd0 && value.significand == 64'd0)
            return tag_zero;
        return tag_valid;
    endfunction

    assign sti_phys  = top_q + read_index;  // Wraps modulo 8
    assign push_phys = top_q - 3'd1;

    assign st0       = regs[top_q];
    assign sti       = regs[sti_phys];
    assign st0_empty = (tags[top_q] == tag_empty);
    assign sti_empty = (tags[sti_phys] == tag_empty);
    assign full      = (tags[push_phys] != tag_empty);
    assign top       = top_q;

    // ========================================
    // Register contents
    // ========================================

    always_ff @(posedge clk) begin
        if (push) begin
            regs[push_phys] <= write_data;
        end else if (write_enable) begin
            regs[top_q] <= write_data;
        end else if (exchange) begin
            regs[top_q]    <= regs[sti_phys];
            regs[sti_phys] <= regs[top_q];
        end
    end

    // ========================================
    // TOP pointer and tags
    // ========================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            top_q <= '0;
            for (int i = 0; i < STACK_DEPTH; i++) begin
                tags[i] <= tag_empty;
            end
        end else if (push) begin
            top_q           <= push_phys;
            tags[push_phys] <= tag_of(write_data);
        end else if (write_enable) begin
            tags[top_q] <= tag_of(write_data);
        end else if (pop) begin
            tags[top_q] <= tag_empty;
            top_q       <= top_q + 3'd1;
        end else if (exchange) begin
            tags[top_q]    <= tags[sti_phys];
            tags[sti_phys] <= tags[top_q];
        end
    end

    // Two bits per physical register, register 0 in the low bits
    always_comb begin
        for (int i = 0; i < STACK_DEPTH; i++) begin
            tag_word[2*i +: 2] = tags[i];
        end
    end

endmodule

/* source/fpu_pkg.sv */
package fpu_pkg;

    // ========================================
    // Data types
    // ========================================

    // 80-bit extended real, explicit integer bit at significand[63]
    typedef struct packed {
        logic        sign;
        logic [14:0] exponent;
        logic [63:0] significand;
    } fp80_t;

    typedef logic [2:0] stack_index_t;  // Relative or physical register number

    typedef enum logic [1:0] {
        tag_valid = 2'b00,
        tag_zero  = 2'b01,
        tag_empty = 2'b11
    } tag_e;

    // Unlisted encodings run as op_nop
    typedef enum logic [7:0] {
        op_nop    = 8'h00,
        op_fld    = 8'h20,  // Push data_in
        op_fst    = 8'h21,  // ST(i) to data_out
        op_fstp   = 8'h22,  // ST(0) to data_out, then pop
        op_fxch   = 8'h23,
        op_fild16 = 8'h30,
        op_fild32 = 8'h31,
        op_fldcw  = 8'hF0,
        op_fclex  = 8'hF3
    } fpu_opcode_e;

    // ========================================
    // Architectural constants
    // ========================================

    localparam int STACK_DEPTH = 8;

    localparam logic [15:0] CONTROL_RESET = 16'h037F;  // All exceptions masked

    // Sign set, exponent all ones, significand C000...
    localparam fp80_t FP80_INDEFINITE = 80'hFFFF_C000_0000_0000_0000;

    localparam logic [14:0] EXP_BIAS = 15'd16383;

    // Status word bit positions
    localparam int SW_IE      = 0;
    localparam int SW_SF      = 6;
    localparam int SW_ES      = 7;
    localparam int SW_C1      = 9;
    localparam int SW_TOP_LSB = 11;  // TOP occupies 13:11
    localparam int SW_BUSY    = 15;

    // Control word, invalid-operation mask
    localparam int CW_IM = 0;

endpackage
